// File: hw/vga_pkg.sv
/*
 * VGA pixel pipeline package
 * Count, colour, ROM address and digit types, plus the glyph geometry
 * and the colours used by the digit overlay
 */
package vga_pkg;

    // Pixel position on either axis
    typedef logic [10:0] count_t;

    // 4 bits each of red, green, blue
    typedef logic [11:0] rgb_t;

    // Glyph ROM word address, 960 words used
    typedef logic [9:0] rom_addr_t;

    // Displayed digit, 0 to 9
    typedef logic [3:0] digit_t;

    // Glyph size in pixels
    localparam int DIGIT_WIDTH  = 8;
    localparam int DIGIT_HEIGHT = 12;

    // One word per glyph pixel
    localparam int GLYPH_WORDS = DIGIT_WIDTH * DIGIT_HEIGHT;

    // Transparent ROM word
    localparam rgb_t COLOR_KEY = 12'hfff;

    // Opaque glyph pixel
    localparam rgb_t GLYPH_COLOR = 12'h00f;

endpackage

// File: hw/delay.sv
/*
 * Fixed delay line
 * Shifts a WIDTH-bit bus through CLK_DEL registers, cleared by reset
 */
module delay #(
    parameter int WIDTH   = 8,
    parameter int CLK_DEL = 1
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [WIDTH-1:0] din,
    output logic [WIDTH-1:0] dout
);

    logic [WIDTH-1:0] stage [CLK_DEL];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < CLK_DEL; i++) begin
                stage[i] <= '0;
            end
        end else begin
            stage[0] <= din;
            for (int i = 1; i < CLK_DEL; i++) begin
                stage[i] <= stage[i-1];      // Shift towards the output
            end
        end
    end

    assign dout = stage[CLK_DEL-1];

endmodule

// File: hw/vga_timing.sv
/*
 * VGA timing generator
 * Free-running pixel and line counters with registered sync and
 * blanking outputs, all active high
 */
module vga_timing #(
    parameter int H_ACTIVE = 640,
    parameter int H_FRONT  = 16,
    parameter int H_SYNC   = 96,
    parameter int H_BACK   = 48,
    parameter int V_ACTIVE = 480,
    parameter int V_FRONT  = 10,
    parameter int V_SYNC   = 2,
    parameter int V_BACK   = 33
) (
    input  logic            clk,
    input  logic            rst,
    output vga_pkg::count_t hcount,
    output vga_pkg::count_t vcount,
    output logic            hsync,
    output logic            vsync,
    output logic            hblnk,
    output logic            vblnk
);

    localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

    localparam vga_pkg::count_t H_LAST     = vga_pkg::count_t'(H_TOTAL - 1);
    localparam vga_pkg::count_t V_LAST     = vga_pkg::count_t'(V_TOTAL - 1);
    localparam vga_pkg::count_t H_SYNC_BEG = vga_pkg::count_t'(H_ACTIVE + H_FRONT);
    localparam vga_pkg::count_t H_SYNC_END = vga_pkg::count_t'(H_ACTIVE + H_FRONT + H_SYNC);
    localparam vga_pkg::count_t V_SYNC_BEG = vga_pkg::count_t'(V_ACTIVE + V_FRONT);
    localparam vga_pkg::count_t V_SYNC_END = vga_pkg::count_t'(V_ACTIVE + V_FRONT + V_SYNC);
    localparam vga_pkg::count_t H_BLNK_BEG = vga_pkg::count_t'(H_ACTIVE);
    localparam vga_pkg::count_t V_BLNK_BEG = vga_pkg::count_t'(V_ACTIVE);

    vga_pkg::count_t h_cnt;
    vga_pkg::count_t v_cnt;
    vga_pkg::count_t h_cnt_nxt;
    vga_pkg::count_t v_cnt_nxt;

    always_comb begin
        h_cnt_nxt = h_cnt + 11'd1;
        v_cnt_nxt = v_cnt;
        if (h_cnt == H_LAST) begin        // End of line
            h_cnt_nxt = '0;
            v_cnt_nxt = (v_cnt == V_LAST) ? '0 : v_cnt + 11'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            h_cnt  <= '0;
            v_cnt  <= '0;
            hcount <= '0;
            vcount <= '0;
            hsync  <= 1'b0;
            vsync  <= 1'b0;
            hblnk  <= 1'b0;
            vblnk  <= 1'b0;
        end else begin
            h_cnt  <= h_cnt_nxt;
            v_cnt  <= v_cnt_nxt;
            hcount <= h_cnt;                 // Decode follows the counter by one clock
            vcount <= v_cnt;
            hsync  <= (h_cnt >= H_SYNC_BEG) && (h_cnt < H_SYNC_END);
            vsync  <= (v_cnt >= V_SYNC_BEG) && (v_cnt < V_SYNC_END);
            hblnk  <= (h_cnt >= H_BLNK_BEG);
            vblnk  <= (v_cnt >= V_BLNK_BEG);
        end
    end

    // Displayed counts never leave the frame
    a_count_range: assert property (@(posedge clk) disable iff (rst)
        (hcount <= H_LAST) && (vcount <= V_LAST));

endmodule

// File: hw/draw_background.sv
/*
 * Background painter
 * Registers the timing group and colours each active pixel from its
 * position, black during blanking
 */
module draw_background (
    input  logic            clk,
    input  logic            rst,
    input  vga_pkg::count_t in_hcount,
    input  vga_pkg::count_t in_vcount,
    input  logic            in_hsync,
    input  logic            in_vsync,
    input  logic            in_hblnk,
    input  logic            in_vblnk,
    output vga_pkg::count_t hcount,
    output vga_pkg::count_t vcount,
    output logic            hsync,
    output logic            vsync,
    output logic            hblnk,
    output logic            vblnk,
    output vga_pkg::rgb_t   rgb
);

    vga_pkg::rgb_t rgb_nxt;

    always_comb begin
        if (in_hblnk || in_vblnk) begin
            rgb_nxt = '0;
        end else begin
            rgb_nxt = {in_hcount[6:3], in_vcount[6:3], 4'h0};  // Red across, green down
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hcount <= '0;
            vcount <= '0;
            hsync  <= 1'b0;
            vsync  <= 1'b0;
            hblnk  <= 1'b0;
            vblnk  <= 1'b0;
            rgb    <= '0;
        end else begin
            hcount <= in_hcount;
            vcount <= in_vcount;
            hsync  <= in_hsync;
            vsync  <= in_vsync;
            hblnk  <= in_hblnk;
            vblnk  <= in_vblnk;
            rgb    <= rgb_nxt;
        end
    end

endmodule

// File: hw/digit_rom.sv
/*
 * Digit glyph ROM
 * Ten 8x12 glyphs, one colour word per pixel, synchronous read.
 * A pixel is opaque when (column + row + digit) mod 3 is zero
 */
module digit_rom (
    input  logic               clk,
    input  vga_pkg::rom_addr_t addr,
    output vga_pkg::rgb_t      data
);

    localparam int NUM_DIGITS = 10;
    localparam int ROM_DEPTH  = NUM_DIGITS * vga_pkg::GLYPH_WORDS;

    vga_pkg::rgb_t mem [ROM_DEPTH];

    // Word address is digit * 96 + row * 8 + column
    initial begin
        for (int d = 0; d < NUM_DIGITS; d++) begin
            for (int r = 0; r < vga_pkg::DIGIT_HEIGHT; r++) begin
                for (int c = 0; c < vga_pkg::DIGIT_WIDTH; c++) begin
                    if (((c + r + d) % 3) == 0) begin
                        mem[d * vga_pkg::GLYPH_WORDS + r * vga_pkg::DIGIT_WIDTH + c] =
                            vga_pkg::GLYPH_COLOR;
                    end else begin
                        mem[d * vga_pkg::GLYPH_WORDS + r * vga_pkg::DIGIT_WIDTH + c] =
                            vga_pkg::COLOR_KEY;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        data <= mem[addr];                   // One clock read latency
    end

endmodule

// File: hw/draw_counter.sv
/*
 * Digit overlay
 * Draws the glyph of the latched digit at a fixed position over the
 * background, ROM words equal to the colour key stay transparent
 */
module draw_counter #(
    parameter int DIGIT_X = 316,
    parameter int DIGIT_Y = 234
) (
    input  logic               clk,
    input  logic               rst,
    input  vga_pkg::digit_t    digit,
    input  vga_pkg::rgb_t      rom_data,
    input  vga_pkg::count_t    in_hcount,
    input  vga_pkg::count_t    in_vcount,
    input  logic               in_hsync,
    input  logic               in_vsync,
    input  logic               in_hblnk,
    input  logic               in_vblnk,
    input  vga_pkg::rgb_t      in_rgb,
    output vga_pkg::rom_addr_t rom_addr,
    output vga_pkg::count_t    hcount,
    output vga_pkg::count_t    vcount,
    output logic               hsync,
    output logic               vsync,
    output logic               hblnk,
    output logic               vblnk,
    output vga_pkg::rgb_t      rgb
);

    localparam vga_pkg::count_t X_BEG = vga_pkg::count_t'(DIGIT_X);
    localparam vga_pkg::count_t X_END = vga_pkg::count_t'(DIGIT_X + vga_pkg::DIGIT_WIDTH);
    localparam vga_pkg::count_t Y_BEG = vga_pkg::count_t'(DIGIT_Y);
    localparam vga_pkg::count_t Y_END = vga_pkg::count_t'(DIGIT_Y + vga_pkg::DIGIT_HEIGHT);

    localparam int BUS_WIDTH = 2 * $bits(vga_pkg::count_t) + 4 + $bits(vga_pkg::rgb_t);

    vga_pkg::digit_t    digit_q;
    vga_pkg::digit_t    digit_sel;
    logic               frame_start;
    logic               in_win;
    logic               win_q;
    logic               win_out_q;
    vga_pkg::count_t    col_rel;
    vga_pkg::count_t    row_rel;
    vga_pkg::rom_addr_t digit_base;
    vga_pkg::rom_addr_t rom_addr_nxt;

    vga_pkg::count_t    hcount_d;
    vga_pkg::count_t    vcount_d;
    logic               hsync_d;
    logic               vsync_d;
    logic               hblnk_d;
    logic               vblnk_d;
    vga_pkg::rgb_t      rgb_d;
    vga_pkg::rgb_t      rgb_bg_q;

    // Timing group waits one clock for the ROM address register
    delay #(
        .WIDTH   (BUS_WIDTH),
        .CLK_DEL (1)
    ) u_delay (
        .clk  (clk),
        .rst  (rst),
        .din  ({in_vcount, in_vblnk, in_vsync, in_hcount, in_hblnk, in_hsync, in_rgb}),
        .dout ({vcount_d, vblnk_d, vsync_d, hcount_d, hblnk_d, hsync_d, rgb_d})
    );

    assign frame_start = (in_hcount == '0) && (in_vcount == '0);
    assign digit_sel   = frame_start ? digit : digit_q;   // New digit valid from pixel (0, 0)

    always_comb begin
        in_win = (in_hcount >= X_BEG) && (in_hcount < X_END) &&
                 (in_vcount >= Y_BEG) && (in_vcount < Y_END);
        col_rel    = in_hcount - X_BEG;
        row_rel    = in_vcount - Y_BEG;
        digit_base = vga_pkg::rom_addr_t'(digit_sel) *
                     vga_pkg::rom_addr_t'(vga_pkg::GLYPH_WORDS);
        if (in_win) begin
            rom_addr_nxt = digit_base + vga_pkg::rom_addr_t'({row_rel[3:0], col_rel[2:0]});
        end else begin
            rom_addr_nxt = digit_base;       // Keeps the address inside the table
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            digit_q   <= '0;
            rom_addr  <= '0;
            win_q     <= 1'b0;
            win_out_q <= 1'b0;
            hcount    <= '0;
            vcount    <= '0;
            hsync     <= 1'b0;
            vsync     <= 1'b0;
            hblnk     <= 1'b0;
            vblnk     <= 1'b0;
            rgb_bg_q  <= '0;
        end else begin
            digit_q   <= digit_sel;
            rom_addr  <= rom_addr_nxt;
            win_q     <= in_win;
            win_out_q <= win_q;              // Lines up with rom_data
            hcount    <= hcount_d;
            vcount    <= vcount_d;
            hsync     <= hsync_d;
            vsync     <= vsync_d;
            hblnk     <= hblnk_d;
            vblnk     <= vblnk_d;
            rgb_bg_q  <= rgb_d;
        end
    end

    // Glyph word replaces the background unless it is the key colour
    assign rgb = (win_out_q && (rom_data != vga_pkg::COLOR_KEY)) ? rom_data : rgb_bg_q;

    a_digit_legal: assert property (@(posedge clk) disable iff (rst)
        digit_q <= 4'd9);

endmodule

// File: hw/vga_top.sv
/*
 * VGA pixel pipeline top level
 * Timing generator, background painter and digit overlay in a chain,
 * with the glyph ROM beside the overlay
 */
module vga_top #(
    parameter int H_ACTIVE = 640,
    parameter int H_FRONT  = 16,
    parameter int H_SYNC   = 96,
    parameter int H_BACK   = 48,
    parameter int V_ACTIVE = 480,
    parameter int V_FRONT  = 10,
    parameter int V_SYNC   = 2,
    parameter int V_BACK   = 33,
    parameter int DIGIT_X  = 316,
    parameter int DIGIT_Y  = 234
) (
    input  logic            clk,
    input  logic            rst,
    input  vga_pkg::digit_t digit,
    output vga_pkg::count_t hcount,
    output vga_pkg::count_t vcount,
    output logic            hsync,
    output logic            vsync,
    output logic            hblnk,
    output logic            vblnk,
    output vga_pkg::rgb_t   rgb
);

    vga_pkg::count_t    tim_hcount;
    vga_pkg::count_t    tim_vcount;
    logic               tim_hsync;
    logic               tim_vsync;
    logic               tim_hblnk;
    logic               tim_vblnk;

    vga_pkg::count_t    bg_hcount;
    vga_pkg::count_t    bg_vcount;
    logic               bg_hsync;
    logic               bg_vsync;
    logic               bg_hblnk;
    logic               bg_vblnk;
    vga_pkg::rgb_t      bg_rgb;

    vga_pkg::rom_addr_t rom_addr;
    vga_pkg::rgb_t      rom_data;

    vga_timing #(
        .H_ACTIVE (H_ACTIVE),
        .H_FRONT  (H_FRONT),
        .H_SYNC   (H_SYNC),
        .H_BACK   (H_BACK),
        .V_ACTIVE (V_ACTIVE),
        .V_FRONT  (V_FRONT),
        .V_SYNC   (V_SYNC),
        .V_BACK   (V_BACK)
    ) u_vga_timing (
        .clk    (clk),
        .rst    (rst),
        .hcount (tim_hcount),
        .vcount (tim_vcount),
        .hsync  (tim_hsync),
        .vsync  (tim_vsync),
        .hblnk  (tim_hblnk),
        .vblnk  (tim_vblnk)
    );

    draw_background u_draw_background (
        .clk       (clk),
        .rst       (rst),
        .in_hcount (tim_hcount),
        .in_vcount (tim_vcount),
        .in_hsync  (tim_hsync),
        .in_vsync  (tim_vsync),
        .in_hblnk  (tim_hblnk),
        .in_vblnk  (tim_vblnk),
        .hcount    (bg_hcount),
        .vcount    (bg_vcount),
        .hsync     (bg_hsync),
        .vsync     (bg_vsync),
        .hblnk     (bg_hblnk),
        .vblnk     (bg_vblnk),
        .rgb       (bg_rgb)
    );

    draw_counter #(
        .DIGIT_X (DIGIT_X),
        .DIGIT_Y (DIGIT_Y)
    ) u_draw_counter (
        .clk       (clk),
        .rst       (rst),
        .digit     (digit),
        .rom_data  (rom_data),
        .in_hcount (bg_hcount),
        .in_vcount (bg_vcount),
        .in_hsync  (bg_hsync),
        .in_vsync  (bg_vsync),
        .in_hblnk  (bg_hblnk),
        .in_vblnk  (bg_vblnk),
        .in_rgb    (bg_rgb),
        .rom_addr  (rom_addr),
        .hcount    (hcount),
        .vcount    (vcount),
        .hsync     (hsync),
        .vsync     (vsync),
        .hblnk     (hblnk),
        .vblnk     (vblnk),
        .rgb       (rgb)
    );

    digit_rom u_digit_rom (
        .clk  (clk),
        .addr (rom_addr),
        .data (rom_data)
    );

endmodule

// File: testbench/vga_top_tb.sv
/*
 * Testbench for the VGA pixel pipeline
 * Directed tests of reset, sync and blanking, background colour,
 * digit glyph overlay and the frame-start digit latch
 */
module vga_top_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int H_ACTIVE = 64;
    localparam int H_FRONT  = 4;
    localparam int H_SYNC   = 8;
    localparam int H_BACK   = 4;
    localparam int V_ACTIVE = 48;
    localparam int V_FRONT  = 2;
    localparam int V_SYNC   = 2;
    localparam int V_BACK   = 2;
    localparam int DIGIT_X  = 20;
    localparam int DIGIT_Y  = 16;

    localparam int H_TOTAL      = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL      = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int FRAME_PIXELS = H_TOTAL * V_TOTAL;
    localparam int WAIT_LIMIT   = FRAME_PIXELS + 16;   // Cycles before a wait gives up
    localparam int GLYPH_W      = 8;
    localparam int GLYPH_H      = 12;
    localparam logic [11:0] GLYPH_BLUE = 12'h00f;

    logic            clk = 1'b0;
    logic            rst;
    vga_pkg::digit_t digit;
    vga_pkg::count_t hcount;
    vga_pkg::count_t vcount;
    logic            hsync;
    logic            vsync;
    logic            hblnk;
    logic            vblnk;
    vga_pkg::rgb_t   rgb;

    integer seed = 32'h2feb819c;

    vga_top #(
        .H_ACTIVE (H_ACTIVE),
        .H_FRONT  (H_FRONT),
        .H_SYNC   (H_SYNC),
        .H_BACK   (H_BACK),
        .V_ACTIVE (V_ACTIVE),
        .V_FRONT  (V_FRONT),
        .V_SYNC   (V_SYNC),
        .V_BACK   (V_BACK),
        .DIGIT_X  (DIGIT_X),
        .DIGIT_Y  (DIGIT_Y)
    ) u_vga_top (
        .clk    (clk),
        .rst    (rst),
        .digit  (digit),
        .hcount (hcount),
        .vcount (vcount),
        .hsync  (hsync),
        .vsync  (vsync),
        .hblnk  (hblnk),
        .vblnk  (vblnk),
        .rgb    (rgb)
    );

    always #20 clk = ~clk;                  // 40 ns period

    // Red from x, green from y, black outside the active area
    function automatic logic [11:0] background_color(input int x, input int y);
        if (x >= H_ACTIVE || y >= V_ACTIVE) begin
            return 12'h000;
        end
        return 12'(((x >> 3) & 15) << 8) | 12'(((y >> 3) & 15) << 4);
    endfunction

    function automatic bit in_window(input int x, input int y);
        return (x >= DIGIT_X) && (x < DIGIT_X + GLYPH_W) &&
               (y >= DIGIT_Y) && (y < DIGIT_Y + GLYPH_H);
    endfunction

    function automatic logic [11:0] expected_rgb(input int d, input int x, input int y);
        if (in_window(x, y) && (((x - DIGIT_X) + (y - DIGIT_Y) + d) % 3 == 0)) begin
            return GLYPH_BLUE;               // Opaque glyph pixel
        end
        return background_color(x, y);
    endfunction

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check(input string test, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected) begin
            fail_run($sformatf("error: %s expected 0x%0h actual 0x%0h",
                               test, expected, actual));
        end
    endtask

    task automatic check_idle(input string test);
        check({test, " hsync"}, 0, hsync);
        check({test, " vsync"}, 0, vsync);
        check({test, " hblnk"}, 0, hblnk);
        check({test, " vblnk"}, 0, vblnk);
        check({test, " rgb"}, 0, rgb);
    endtask

    // Returns on the first output pixel (0, 0) of a new frame
    task automatic wait_frame_start();
        int n;
        n = 0;
        while (hcount == 0 && vcount == 0) begin
            @(negedge clk);
            n++;
            if (n > WAIT_LIMIT) fail_run("timeout: outputs never left pixel (0, 0)");
        end
        n = 0;
        while (!(hcount == 0 && vcount == 0)) begin
            @(negedge clk);
            n++;
            if (n > WAIT_LIMIT) fail_run("timeout: no frame start seen on the outputs");
        end
    endtask

    task automatic wait_pixel(input int x, input int y);
        int n;
        n = 0;
        while (!(hcount == x && vcount == y)) begin
            @(negedge clk);
            n++;
            if (n > WAIT_LIMIT) fail_run("timeout: requested pixel never shown");
        end
    endtask

    task automatic drive_digit(input vga_pkg::digit_t d);
        @(posedge clk);
        #2;
        digit = d;
    endtask

    task automatic check_pixels(input string test, input int d, input int count);
        for (int i = 0; i < count; i++) begin
            check(test, expected_rgb(d, hcount, vcount), rgb);
            @(negedge clk);
        end
    endtask

    task automatic reset_outputs();
        for (int i = 0; i < 4; i++) begin
            @(posedge clk);
            #2;
            check_idle("reset");
        end
        rst = 1'b0;
        for (int i = 0; i < 2; i++) begin
            @(negedge clk);
            check_idle("reset_release");
        end
    endtask

    task automatic sync_and_blanking();
        int x;
        int y;
        for (int i = 0; i < FRAME_PIXELS; i++) begin
            x = i % H_TOTAL;
            y = i / H_TOTAL;
            check("sync_blank hcount", x, hcount);
            check("sync_blank vcount", y, vcount);
            check("sync_blank hsync", (x >= H_ACTIVE + H_FRONT) &&
                  (x < H_ACTIVE + H_FRONT + H_SYNC), hsync);
            check("sync_blank vsync", (y >= V_ACTIVE + V_FRONT) &&
                  (y < V_ACTIVE + V_FRONT + V_SYNC), vsync);
            check("sync_blank hblnk", x >= H_ACTIVE, hblnk);
            check("sync_blank vblnk", y >= V_ACTIVE, vblnk);
            @(negedge clk);
        end
        check("sync_blank hcount wrap", 0, hcount);
        check("sync_blank vcount wrap", 0, vcount);
    endtask

    task automatic background_frame();
        for (int i = 0; i < FRAME_PIXELS; i++) begin
            if (!in_window(hcount, vcount)) begin
                check("background", background_color(hcount, vcount), rgb);
            end
            @(negedge clk);
        end
    endtask

    task automatic digit_glyph();
        wait_pixel(0, 32);                   // Window already drawn in this frame
        drive_digit(4'd7);
        wait_frame_start();
        check_pixels("digit_glyph", 7, FRAME_PIXELS);
    endtask

    task automatic frame_start_latch();
        int shown;
        int next_d;
        int remaining;
        shown = 7;
        for (int k = 0; k < 4; k++) begin
            next_d = $unsigned($random(seed)) % 10;
            if ((next_d % 3) == (shown % 3)) begin
                next_d = (next_d == 9) ? 1 : next_d + 1;   // Same residue draws the same glyph
            end
            wait_pixel(0, 4);                // Above the window
            drive_digit(vga_pkg::digit_t'(next_d));
            @(negedge clk);
            remaining = FRAME_PIXELS - (vcount * H_TOTAL + hcount);
            check_pixels("latch_old_digit", shown, remaining);
            check("latch_frame_start hcount", 0, hcount);
            check("latch_frame_start vcount", 0, vcount);
            check_pixels("latch_new_digit", next_d, FRAME_PIXELS);
            shown = next_d;
        end
    endtask

    initial begin
        rst   = 1'b1;
        digit = '0;
        reset_outputs();
        wait_frame_start();
        sync_and_blanking();
        background_frame();
        digit_glyph();
        frame_start_latch();
        $display("Simulation passed");
        $finish;
    end

endmodule

// File: flist.f
hw/vga_pkg.sv
hw/delay.sv
hw/vga_timing.sv
hw/draw_background.sv
hw/digit_rom.sv
hw/draw_counter.sv
hw/vga_top.sv
testbench/vga_top_tb.sv

// File: Bender.yml
package:
  name: vga_digit_overlay

sources:
  - hw/vga_pkg.sv
  - hw/delay.sv
  - hw/vga_timing.sv
  - hw/draw_background.sv
  - hw/digit_rom.sv
  - hw/draw_counter.sv
  - hw/vga_top.sv
  - target: simulation
    files:
      - testbench/vga_top_tb.sv
